// File: design/zx_ula_pkg.sv
`default_nettype none

package zx_ula_pkg;

	// full 16-bit decoded ports
	localparam logic [15:0] PORT_DFFD = 16'hdffd; // extended ram bank port
	localparam logic [15:0] PORT_1FFD = 16'h1ffd; // +3 paging port

	// kempston answers when a7..a5 are all low
	localparam logic [7:0] KEMPSTON_MASK = 8'he0;

	localparam logic [1:0] HI_MAIN = 2'b11; // upper page field of main 128k
	localparam logic [1:0] RAM_EXT_RESET = 2'b11; // ext bank bits are stored inverted
	localparam logic RD_FE_TOP = 1'b1; // bit 7 of fe read, ear not wired

	// cpu bus as seen by the ula, strobes active low
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] data_wr;
		logic n_rd;
		logic n_wr;
		logic n_mreq;
		logic n_iorq;
		logic n_m1;
		logic n_rfsh;
	} cpu_bus_t;

	// joystick lines, low when pressed
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic b1;
		logic b2;
		logic b3;
	} joy_t;

	// registered port hits, one cycle behind the bus
	typedef struct packed {
		logic wr_fe;
		logic wr_7ffd;
		logic wr_dffd;
		logic wr_1ffd;
		logic rd_fe;
		logic rd_kempston;
	} port_sel_t;

	typedef struct packed {
		logic [2:0] border; // port fe
		logic beeper;
		logic tape_out;
		logic [2:0] ram_bank; // port 7ffd
		logic scr_bank;
		logic rom_bank;
		logic lock_7ffd;
		logic [1:0] ram_ext; // port dffd, inverted bits 1:0
		logic dffd_d3; // 4000 follows 7ffd bank
		logic dffd_d4; // all ram, also unlocks 7ffd
		logic [2:0] p1ffd; // port 1ffd bits 2:0
	} page_regs_t;

	typedef struct packed {
		logic [4:0] va_page; // {hi, bank}
		logic [1:0] rom_page;
		logic n_romcs;
		logic n_vrd;
		logic n_vwr;
		logic scr_bank; // for the board video side
	} mem_ctrl_t;

endpackage

`default_nettype wire

// File: design/zx_port_decode.sv
`default_nettype none

module zx_port_decode (
	input logic clk28,
	input logic rst_n,
	input zx_ula_pkg::cpu_bus_t bus,
	output zx_ula_pkg::port_sel_t sel
);

	import zx_ula_pkg::*;

	logic io_cycle;
	logic io_wr;
	logic io_rd;
	logic hit_fe;
	logic hit_7ffd;
	logic hit_dffd;
	logic hit_1ffd;
	logic hit_kempston;

	// m1 with iorq is an interrupt ack, not a port access
	assign io_cycle = !bus.n_iorq && bus.n_m1;
	assign io_wr = io_cycle && !bus.n_wr;
	assign io_rd = io_cycle && !bus.n_rd;

	assign hit_fe = !bus.addr[0];
	assign hit_7ffd = !bus.addr[1] && !bus.addr[15] && bus.addr[14]; // partial decode
	assign hit_dffd = bus.addr == PORT_DFFD;
	assign hit_1ffd = bus.addr == PORT_1FFD;
	assign hit_kempston = (bus.addr[7:0] & KEMPSTON_MASK) == 8'h00;

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			sel <= '0;
		end else begin
			sel.wr_fe <= io_wr && hit_fe;
			sel.wr_7ffd <= io_wr && hit_7ffd;
			sel.wr_dffd <= io_wr && hit_dffd;
			sel.wr_1ffd <= io_wr && hit_1ffd;
			sel.rd_fe <= io_rd && hit_fe;
			sel.rd_kempston <= io_rd && hit_kempston; // read only port
		end
	end

endmodule

`default_nettype wire

// File: design/zx_port_regs.sv
`default_nettype none

module zx_port_regs (
	input logic clk28,
	input logic rst_n,
	input zx_ula_pkg::port_sel_t sel,
	input logic [7:0] data_wr,
	output zx_ula_pkg::page_regs_t regs
);

	import zx_ula_pkg::*;

	logic [2:0] border;
	logic beeper;
	logic tape_out;
	logic [2:0] ram_bank;
	logic scr_bank;
	logic rom_bank;
	logic lock_7ffd;
	logic [1:0] ram_ext;
	logic dffd_d3;
	logic dffd_d4;
	logic [2:0] p1ffd;
	logic wr_7ffd_ok;

	// lock is overridden while dffd bit 4 is set
	assign wr_7ffd_ok = sel.wr_7ffd && (!lock_7ffd || dffd_d4);

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			border <= 3'd0;
			beeper <= 1'b0;
			tape_out <= 1'b0;
		end else if (sel.wr_fe) begin
			border <= data_wr[2:0];
			tape_out <= data_wr[3];
			beeper <= data_wr[4];
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			ram_bank <= 3'd0;
			scr_bank <= 1'b0;
			rom_bank <= 1'b0;
			lock_7ffd <= 1'b0;
		end else if (wr_7ffd_ok) begin
			ram_bank <= data_wr[2:0];
			scr_bank <= data_wr[3];
			rom_bank <= data_wr[4];
			lock_7ffd <= data_wr[5];
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			ram_ext <= RAM_EXT_RESET;
			dffd_d3 <= 1'b0;
			dffd_d4 <= 1'b0;
		end else if (sel.wr_dffd) begin
			ram_ext <= ~data_wr[1:0]; // 0 written selects the top 128k
			dffd_d3 <= data_wr[3];
			dffd_d4 <= data_wr[4];
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			p1ffd <= 3'd0;
		end else if (sel.wr_1ffd) begin
			p1ffd <= data_wr[2:0];
		end
	end

	always_comb begin
		regs.border = border;
		regs.beeper = beeper;
		regs.tape_out = tape_out;
		regs.ram_bank = ram_bank;
		regs.scr_bank = scr_bank;
		regs.rom_bank = rom_bank;
		regs.lock_7ffd = lock_7ffd;
		regs.ram_ext = ram_ext;
		regs.dffd_d3 = dffd_d3;
		regs.dffd_d4 = dffd_d4;
		regs.p1ffd = p1ffd;
	end

endmodule

`default_nettype wire

// File: design/zx_mem_map.sv
`default_nettype none

module zx_mem_map (
	input logic clk28,
	input logic rst_n,
	input zx_ula_pkg::cpu_bus_t bus,
	input zx_ula_pkg::page_regs_t regs,
	output zx_ula_pkg::mem_ctrl_t mem,
	output logic [13:0] va_low
);

	import zx_ula_pkg::*;

	logic a15;
	logic a14;
	logic mem_cycle;
	logic low_quarter;
	logic all_ram;
	logic rom_sel;
	logic rom_req;
	logic ram_req;
	logic [4:0] page_next;
	logic [4:0] page;

	assign a15 = bus.addr[15];
	assign a14 = bus.addr[14];
	assign mem_cycle = !bus.n_mreq && bus.n_rfsh; // refresh never touches memory
	assign low_quarter = !a15 && !a14;
	assign all_ram = regs.dffd_d4 || regs.p1ffd[0];
	assign rom_sel = low_quarter && !all_ram;

	// first matching rule wins
	always_comb begin
		if (regs.dffd_d3 && a15) begin
			page_next = {HI_MAIN, a14, a15, a14};
		end else if (regs.dffd_d3 && a14) begin
			page_next = {regs.ram_ext, regs.ram_bank};
		end else if (!regs.p1ffd[2] && regs.p1ffd[0]) begin
			page_next = {HI_MAIN, regs.p1ffd[1], a15, a14}; // banks 0-3 or 4-7
		end else if (regs.p1ffd == 3'b101) begin
			page_next = {HI_MAIN, ~(a15 & a14), a15, a14}; // 4 5 6 3
		end else if (regs.p1ffd == 3'b111) begin
			page_next = {HI_MAIN, ~(a15 & a14), a15 | a14, a14}; // 4 7 6 3
		end else if (a15 && a14) begin
			page_next = {regs.ram_ext, regs.ram_bank};
		end else begin
			page_next = {HI_MAIN, a14, a15, a14}; // 0 5 2
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			rom_req <= 1'b0;
			ram_req <= 1'b0;
		end else begin
			rom_req <= mem_cycle && rom_sel;
			ram_req <= mem_cycle && !rom_sel;
		end
	end

	always_ff @(posedge clk28) begin
		page <= page_next;
	end

	// requests are registered, the strobes themselves follow the live bus
	always_comb begin
		mem.va_page = page;
		mem.rom_page = {regs.p1ffd[2], regs.rom_bank};
		mem.n_romcs = !(rom_req && !bus.n_mreq);
		mem.n_vrd = !(ram_req && !bus.n_rd);
		mem.n_vwr = !(ram_req && !bus.n_wr);
		mem.scr_bank = regs.scr_bank;
	end

	assign va_low = bus.addr[13:0];

endmodule

`default_nettype wire

// File: design/zx_read_mux.sv
`default_nettype none

module zx_read_mux (
	input zx_ula_pkg::port_sel_t sel,
	input logic [4:0] kd,
	input logic tape_in,
	input zx_ula_pkg::joy_t joy,
	output logic [7:0] rd_data,
	output logic rd_oe
);

	import zx_ula_pkg::*;

	logic [7:0] fe_data;
	logic [7:0] kempston_data;

	assign fe_data = {RD_FE_TOP, tape_in, 1'b1, kd};

	// kempston is active high, the lines are not
	assign kempston_data = {
		1'b0,
		~joy.b3,
		~joy.b2,
		~joy.b1,
		~joy.up,
		~joy.down,
		~joy.left,
		~joy.right
	};

	always_comb begin
		if (sel.rd_fe) begin
			rd_data = fe_data; // fe wins over kempston
		end else if (sel.rd_kempston) begin
			rd_data = kempston_data;
		end else begin
			rd_data = 8'hff; // idle bus
		end
	end

	assign rd_oe = sel.rd_fe || sel.rd_kempston;

endmodule

`default_nettype wire

// File: design/zx_bus_ula.sv
`default_nettype none

module zx_bus_ula (
	input logic clk28,
	input logic rst_n,
	input zx_ula_pkg::cpu_bus_t bus,
	input logic [4:0] kd,
	input logic tape_in,
	input zx_ula_pkg::joy_t joy,
	output zx_ula_pkg::mem_ctrl_t mem,
	output logic [13:0] va_low,
	output logic [7:0] rd_data,
	output logic rd_oe,
	output logic [2:0] border,
	output logic beeper,
	output logic tape_out
);

	import zx_ula_pkg::*;

	port_sel_t sel;
	page_regs_t regs;

	zx_port_decode u_decode (
		.clk28 (clk28),
		.rst_n (rst_n),
		.bus (bus),
		.sel (sel)
	);

	zx_port_regs u_regs (
		.clk28 (clk28),
		.rst_n (rst_n),
		.sel (sel),
		.data_wr (bus.data_wr),
		.regs (regs)
	);

	zx_mem_map u_mem_map (
		.clk28 (clk28),
		.rst_n (rst_n),
		.bus (bus),
		.regs (regs),
		.mem (mem),
		.va_low (va_low)
	);

	zx_read_mux u_read_mux (
		.sel (sel),
		.kd (kd),
		.tape_in (tape_in),
		.joy (joy),
		.rd_data (rd_data),
		.rd_oe (rd_oe)
	);

	assign border = regs.border;
	assign beeper = regs.beeper;
	assign tape_out = regs.tape_out;

endmodule

`default_nettype wire

// File: sim/zx_bus_ula_sva.sv
`default_nettype none

module zx_bus_ula_sva (
	input logic clk28,
	input logic rst_n,
	input zx_ula_pkg::cpu_bus_t bus,
	input zx_ula_pkg::mem_ctrl_t mem,
	input logic rd_oe,
	input logic [2:0] border
);

	timeunit 1ns;
	timeprecision 1ps;

	logic io_rd;

	assign io_rd = !bus.n_iorq && !bus.n_rd && bus.n_m1; // int ack excluded

	a_strobe_excl: assert property (@(posedge clk28) disable iff (!rst_n)
		!(!mem.n_vrd && !mem.n_romcs))
		else $error("n_vrd and n_romcs are low together");

	a_vwr_write: assert property (@(posedge clk28) disable iff (!rst_n)
		!mem.n_vwr |-> !bus.n_wr && !bus.n_mreq)
		else $error("n_vwr is low outside a memory write");

	// read flags lag the bus by one cycle
	a_oe_read: assert property (@(posedge clk28) disable iff (!rst_n)
		rd_oe |-> $past(io_rd))
		else $error("rd_oe is set without an io read");

	a_reset: assert property (@(posedge clk28)
		!rst_n |-> !rd_oe && mem.n_romcs && mem.n_vrd && mem.n_vwr && border == 3'd0)
		else $error("outputs are not at their reset values");

endmodule

bind zx_bus_ula zx_bus_ula_sva u_sva (
	.clk28 (clk28),
	.rst_n (rst_n),
	.bus (bus),
	.mem (mem),
	.rd_oe (rd_oe),
	.border (border)
);

`default_nettype wire

// File: sim/zx_bus_ula_tb.sv
`default_nettype none

module zx_bus_ula_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import zx_ula_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES = 4;
	localparam int IDLE_CYCLES = 2;
	localparam int OP_CYCLES = 8; // budget per operation for the watchdog
	localparam int MAX_TESTS = 64;
	localparam int RAND_WRITES = 8;
	localparam logic [3:0] OP_IO_WR = 4'h1;
	localparam logic [3:0] OP_IO_RD = 4'h2;
	localparam logic [3:0] OP_MEM_RD = 4'h3;
	localparam logic [3:0] OP_MEM_WR = 4'h4;

	logic clk28;
	logic rst_n;
	cpu_bus_t bus;
	logic [4:0] kd;
	logic tape_in;
	joy_t joy;
	mem_ctrl_t mem;
	logic [13:0] va_low;
	logic [7:0] rd_data;
	logic rd_oe;
	logic [2:0] border;
	logic beeper;
	logic tape_out;

	logic [15:0] tests_mem [0:MAX_TESTS*5-1]; // five words per line
	int n_tests;
	int n_checks;
	int n_errors;
	logic [31:0] lcg_state;

	zx_bus_ula u_zx_bus_ula (
		.clk28 (clk28),
		.rst_n (rst_n),
		.bus (bus),
		.kd (kd),
		.tape_in (tape_in),
		.joy (joy),
		.mem (mem),
		.va_low (va_low),
		.rd_data (rd_data),
		.rd_oe (rd_oe),
		.border (border),
		.beeper (beeper),
		.tape_out (tape_out)
	);

	initial clk28 = 1'b0;
	always #(CLK_PERIOD / 2) clk28 = ~clk28;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		lcg_next = state * 32'd1664525 + 32'd1013904223;
	endfunction

	// inputs change 2 ns after the edge
	task automatic next_cycle();
		@(posedge clk28);
		#2;
	endtask

	task automatic idle_bus();
		bus.n_rd = 1'b1;
		bus.n_wr = 1'b1;
		bus.n_mreq = 1'b1;
		bus.n_iorq = 1'b1;
		bus.n_m1 = 1'b1;
		bus.n_rfsh = 1'b1;
	endtask

	task automatic check_mem(input int idx, input mem_ctrl_t exp_mem,
		input logic [13:0] exp_va_low);
		n_checks++;
		if (mem !== exp_mem) begin
			n_errors++;
			$display("FAILED test %0d: mem got %h expected %h", idx, mem, exp_mem);
		end
		if (va_low !== exp_va_low) begin
			n_errors++;
			$display("FAILED test %0d: va_low got %h expected %h", idx, va_low, exp_va_low);
		end
	endtask

	task automatic check_rd(input int idx, input logic exp_oe, input logic [7:0] exp_data);
		n_checks++;
		if (rd_oe !== exp_oe) begin
			n_errors++;
			$display("FAILED test %0d: rd_oe got %h expected %h", idx, rd_oe, exp_oe);
		end else if (exp_oe && rd_data !== exp_data) begin
			n_errors++;
			$display("FAILED test %0d: rd_data got %h expected %h", idx, rd_data, exp_data);
		end
	endtask

	task automatic check_fe(input int idx, input logic [2:0] exp_border,
		input logic exp_beeper, input logic exp_tape_out);
		n_checks++;
		if ({border, beeper, tape_out} !== {exp_border, exp_beeper, exp_tape_out}) begin
			n_errors++;
			$display("FAILED test %0d: border %h beeper %h tape_out %h expected %h %h %h",
				idx, border, beeper, tape_out, exp_border, exp_beeper, exp_tape_out);
		end
	endtask

	// inputs word is {m1_low, 2'b0, joy, tape_in, kd}
	task automatic run_op(input int idx, input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [15:0] inputs, input logic [15:0] exp_val);
		logic [13:0] exp_va_low;
		exp_va_low = addr[13:0];
		if (op == OP_MEM_RD || op == OP_MEM_WR) begin
			lcg_state = lcg_next(lcg_state);
			exp_va_low = addr[13:0] ^ lcg_state[29:16]; // low bits never move the page
		end
		bus.addr = {addr[15:14], exp_va_low};
		bus.data_wr = data;
		kd = inputs[4:0];
		tape_in = inputs[5];
		joy = inputs[12:6];
		bus.n_m1 = ~inputs[15];
		case (op)
			OP_IO_WR: begin
				bus.n_iorq = 1'b0;
				bus.n_wr = 1'b0;
			end
			OP_IO_RD: begin
				bus.n_iorq = 1'b0;
				bus.n_rd = 1'b0;
			end
			OP_MEM_RD: begin
				bus.n_mreq = 1'b0;
				bus.n_rd = 1'b0;
			end
			OP_MEM_WR: begin
				bus.n_mreq = 1'b0;
				bus.n_wr = 1'b0;
			end
			default: idle_bus();
		endcase
		repeat (HOLD_CYCLES) next_cycle();
		case (op)
			OP_IO_WR: check_fe(idx, exp_val[2:0], exp_val[4], exp_val[3]);
			OP_IO_RD: check_rd(idx, exp_val[8], exp_val[7:0]);
			OP_MEM_RD, OP_MEM_WR: check_mem(idx, exp_val[10:0], exp_va_low);
			default: begin
				n_errors++;
				$display("test %0d has an unknown op code %h", idx, op);
			end
		endcase
		idle_bus();
		repeat (IDLE_CYCLES) next_cycle();
	endtask

	initial begin
		logic [7:0] rand_data;
		int i;
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		lcg_state = 32'h3d92;
		rst_n = 1'b1;
		bus = '0;
		idle_bus();
		kd = 5'h1f;
		tape_in = 1'b0;
		joy = '1; // nothing pressed
		$readmemh("sim/zx_bus_ula_tests.txt", tests_mem);
		while (n_tests < MAX_TESTS && tests_mem[n_tests*5] != 16'h000f) n_tests++;
		#1;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) next_cycle();
		rst_n = 1'b1;
		next_cycle();
		if (n_tests == 0) begin
			n_errors++;
			$display("the test file holds no bus operations");
		end
		for (i = 0; i < n_tests; i++) begin
			run_op(i, tests_mem[i*5][3:0], tests_mem[i*5+1], tests_mem[i*5+2][7:0],
				tests_mem[i*5+3], tests_mem[i*5+4]);
		end
		for (i = 0; i < RAND_WRITES; i++) begin
			lcg_state = lcg_next(lcg_state);
			rand_data = lcg_state[23:16];
			run_op(n_tests + i, OP_IO_WR, 16'h00fe, rand_data, 16'h0000,
				{11'd0, rand_data[4], rand_data[3], rand_data[2:0]}); // beeper tape border
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#1;
		#((n_tests + RAND_WRITES) * OP_CYCLES * CLK_PERIOD + (RESET_CYCLES + 2) * CLK_PERIOD);
		$display("timeout: the bus operations did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/zx_bus_ula_tests.txt
// each line holds op addr data inputs expected as hex words with op 1 io write 2 io read 3 mem read 4 mem write and f for the end
// inputs pack {m1_low 00 joy tape_in kd} and expected packs {beeper tape_out border} or {rd_oe rd_data} or mem_ctrl_t
1 00fe 15 0000 015
1 00fe 0a 0000 00a
2 00fe 00 1ff3 1f3
2 00fe 00 1fca 1aa
3 0000 00 0000 606
3 4000 00 0000 74a
3 8000 00 0000 68a
1 7ffd 13 0000 00a
3 c000 00 0000 6da
3 0000 00 0000 616
4 c000 00 0000 6dc
1 7ffd 2e 0000 00a
3 c000 00 0000 78b
1 7ffd 01 0000 00a
3 c000 00 0000 78b
1 dffd 13 0000 00a
1 7ffd 01 0000 00a
3 c000 00 0000 04a
1 dffd 0a 0000 00a
3 4000 00 0000 24a
3 c000 00 0000 7ca
3 0000 00 0000 606
1 dffd 00 0000 00a
1 1ffd 01 0000 00a
3 0000 00 0000 60a
3 c000 00 0000 6ca
1 1ffd 03 0000 00a
3 0000 00 0000 70a
1 1ffd 05 0000 00a
3 0000 00 0000 72a
3 8000 00 0000 7aa
1 1ffd 07 0000 00a
3 4000 00 0000 7ea
3 c000 00 0000 6ea
1 1ffd 04 0000 00a
3 0000 00 0000 626
4 0000 00 0000 626
2 001f 00 0edf 111
2 001f 00 1d80 148
2 00fe 00 9fdf 000
2 001e 00 0025 1e5
1 00fe 07 0000 007
f 0000 00 0000 000

// File: filelist.f
design/zx_ula_pkg.sv
design/zx_port_decode.sv
design/zx_port_regs.sv
design/zx_mem_map.sv
design/zx_read_mux.sv
design/zx_bus_ula.sv
sim/zx_bus_ula_sva.sv
sim/zx_bus_ula_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module zx_bus_ula_tb -f filelist.f -o zx_bus_ula_sim

out=$(./obj_dir/zx_bus_ula_sim || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'all tests passed'
